/* include/bus_macros.svh */
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// Number of node stations sharing the bus
`define BUS_NODE_COUNT 16

// Frame field widths
`define BUS_DATA_WIDTH 64
`define BUS_CRC_WIDTH 4
`define BUS_ADDR_WIDTH 4

// CRC-4 generator x^4+x+1 with the x^4 term implied
`define BUS_CRC_POLY 4'h3

`endif

/* rtl/busPkg.sv */
`default_nettype none
`include "bus_macros.svh"

package busPkg;

	//////////////////////////////////////////////////////////////////////
	// Frame field types
	//////////////////////////////////////////////////////////////////////

	typedef logic [`BUS_DATA_WIDTH-1:0] frameData_t;
	typedef logic [`BUS_CRC_WIDTH-1:0] crc_t;
	typedef logic [`BUS_ADDR_WIDTH-1:0] nodeAddr_t;
	typedef logic [`BUS_NODE_COUNT-1:0] nodeMask_t;

	//////////////////////////////////////////////////////////////////////
	// CRC-4 over one data word, MSB first, zero seed, no final xor
	//////////////////////////////////////////////////////////////////////

	function automatic crc_t crc4(input frameData_t data);
		crc_t crc;
		logic feedback;
		crc = '0;
		for (int i = `BUS_DATA_WIDTH - 1; i >= 0; i--) begin
			feedback = crc[`BUS_CRC_WIDTH-1] ^ data[i];
			crc = {crc[`BUS_CRC_WIDTH-2:0], 1'b0};
			if (feedback) begin
				crc = crc ^ `BUS_CRC_POLY;
			end
		end
		return crc;
	endfunction

endpackage

`default_nettype wire

/* rtl/txDispatcher.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bus_macros.svh"

module txDispatcher (
	input wire logic clock,
	input wire logic rst,
	input wire logic cmdReq,
	input wire busPkg::nodeMask_t cmdMask,
	output logic cmdAck,
	output busPkg::nodeMask_t start,
	input wire busPkg::nodeMask_t done
);

	// Stations started by the current command and not yet finished
	busPkg::nodeMask_t pending;
	busPkg::nodeMask_t remaining;
	logic busy;

	assign remaining = pending & ~done;

	always_ff @(posedge clock) begin
		if (rst) begin
			pending <= {`BUS_NODE_COUNT{1'b0}};
			start <= {`BUS_NODE_COUNT{1'b0}};
			busy <= 1'b0;
			cmdAck <= 1'b0;
		end else begin
			// Start is a single cycle pulse
			start <= {`BUS_NODE_COUNT{1'b0}};

			if (cmdAck) begin
				// Wait for the host to release its request
				if (!cmdReq) begin
					cmdAck <= 1'b0;
				end
			end else if (busy) begin
				pending <= remaining;
				// An empty mask falls through here on the next cycle
				if (remaining == {`BUS_NODE_COUNT{1'b0}}) begin
					busy <= 1'b0;
					cmdAck <= 1'b1;
				end
			end else if (cmdReq) begin
				// New command, kick every masked station at once
				pending <= cmdMask;
				start <= cmdMask;
				busy <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/txStation.sv */
`timescale 1ns/1ps
`default_nettype none

module txStation (
	input wire logic clock,
	input wire logic rst,
	input wire logic start,
	output logic done,
	input wire busPkg::frameData_t frameIn,
	input wire busPkg::crc_t crcIn,
	input wire busPkg::nodeAddr_t dstIn,
	output logic stReq,
	input wire logic stAck,
	output busPkg::frameData_t frameOut,
	output busPkg::crc_t crcOut,
	output busPkg::nodeAddr_t dstOut
);

	typedef enum logic [1:0] {
		stationIdle,
		stationRequest,
		stationRelease
	} stationState_t;

	stationState_t state;

	// Request is held for the whole requesting state
	assign stReq = (state == stationRequest);

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= stationIdle;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				stationIdle: if (start) state <= stationRequest;
				stationRequest: if (stAck) state <= stationRelease;
				stationRelease: begin
					// Collector has let go, transfer finished
					if (!stAck) begin
						done <= 1'b1;
						state <= stationIdle;
					end
				end
				default: state <= stationIdle;
			endcase
		end
	end

	// Local copy of the frame, host inputs are free after start
	always_ff @(posedge clock) begin
		if (start && state == stationIdle) begin
			frameOut <= frameIn;
			crcOut <= crcIn;
			dstOut <= dstIn;
		end
	end

endmodule

`default_nettype wire

/* rtl/busCollector.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bus_macros.svh"

module busCollector (
	input wire logic clock,
	input wire logic rst,
	input wire busPkg::nodeMask_t stReq,
	output busPkg::nodeMask_t stAck,
	input wire busPkg::frameData_t frameIn [`BUS_NODE_COUNT],
	input wire busPkg::crc_t crcIn [`BUS_NODE_COUNT],
	input wire busPkg::nodeAddr_t dstIn [`BUS_NODE_COUNT],
	output logic outReq,
	input wire logic outAck,
	output busPkg::nodeAddr_t outSrc,
	output busPkg::nodeAddr_t outDst,
	output busPkg::frameData_t outData,
	output logic outCrcOk
);

	typedef enum logic [1:0] {
		colIdle,
		colAck,
		colOut,
		colDrain
	} colState_t;

	colState_t state;
	busPkg::nodeAddr_t rrPtr;
	busPkg::nodeAddr_t candidate;
	busPkg::nodeAddr_t grantIdx;
	logic grantValid;
	busPkg::crc_t crcHeld;
	logic stationReleased;

	//////////////////////////////////////////////////////////////////////
	// Round-robin pick
	//////////////////////////////////////////////////////////////////////

	// Walk down from the far end so the nearest pending node wins
	always_comb begin
		grantIdx = rrPtr;
		grantValid = 1'b0;
		candidate = rrPtr;
		for (int k = `BUS_NODE_COUNT - 1; k >= 0; k--) begin
			candidate = rrPtr + busPkg::nodeAddr_t'(k);
			if (stReq[candidate]) begin
				grantIdx = candidate;
				grantValid = 1'b1;
			end
		end
	end

	// outSrc holds the granted node while its handshake runs
	assign stationReleased = (state == colAck) && !stReq[outSrc];

	//////////////////////////////////////////////////////////////////////
	// Handshake control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= colIdle;
			rrPtr <= '0;
			stAck <= '0;
			outReq <= 1'b0;
		end else begin
			case (state)
				colIdle: begin
					if (grantValid) begin
						stAck[grantIdx] <= 1'b1;
						state <= colAck;
					end
				end
				colAck: begin
					// Station dropped its request, frame goes out
					if (stationReleased) begin
						stAck <= '0;
						outReq <= 1'b1;
						rrPtr <= outSrc + busPkg::nodeAddr_t'(1);
						state <= colOut;
					end
				end
				colOut: begin
					if (outAck) begin
						outReq <= 1'b0;
						state <= colDrain;
					end
				end
				colDrain: begin
					// Consumer must release before the next grant
					if (!outAck) state <= colIdle;
				end
				default: state <= colIdle;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Frame copy and CRC check
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (state == colIdle && grantValid) begin
			outSrc <= grantIdx;
			outDst <= dstIn[grantIdx];
			outData <= frameIn[grantIdx];
			crcHeld <= crcIn[grantIdx];
		end
		// Checked off the held copy, ready together with outReq
		if (stationReleased) begin
			outCrcOk <= (busPkg::crc4(outData) == crcHeld);
		end
	end

endmodule

`default_nettype wire

/* rtl/busFabric.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bus_macros.svh"

module busFabric (
	input wire logic clock,
	input wire logic rst,
	input wire logic cmdReq,
	input wire busPkg::nodeMask_t cmdMask,
	output logic cmdAck,
	input wire busPkg::frameData_t frameData [`BUS_NODE_COUNT],
	input wire busPkg::crc_t frameCrc [`BUS_NODE_COUNT],
	input wire busPkg::nodeAddr_t receiverAddr [`BUS_NODE_COUNT],
	output logic outReq,
	input wire logic outAck,
	output busPkg::nodeAddr_t outSrc,
	output busPkg::nodeAddr_t outDst,
	output busPkg::frameData_t outData,
	output logic outCrcOk
);

	busPkg::nodeMask_t startVec;
	busPkg::nodeMask_t doneVec;
	busPkg::nodeMask_t stReqVec;
	busPkg::nodeMask_t stAckVec;
	busPkg::frameData_t stFrame [`BUS_NODE_COUNT];
	busPkg::crc_t stCrc [`BUS_NODE_COUNT];
	busPkg::nodeAddr_t stDst [`BUS_NODE_COUNT];

	txDispatcher dispatcher (
		.clock(clock),
		.rst(rst),
		.cmdReq(cmdReq),
		.cmdMask(cmdMask),
		.cmdAck(cmdAck),
		.start(startVec),
		.done(doneVec)
	);

	// One station per node
	for (genvar i = 0; i < `BUS_NODE_COUNT; i++) begin : genStation
		txStation station (
			.clock(clock),
			.rst(rst),
			.start(startVec[i]),
			.done(doneVec[i]),
			.frameIn(frameData[i]),
			.crcIn(frameCrc[i]),
			.dstIn(receiverAddr[i]),
			.stReq(stReqVec[i]),
			.stAck(stAckVec[i]),
			.frameOut(stFrame[i]),
			.crcOut(stCrc[i]),
			.dstOut(stDst[i])
		);
	end

	busCollector collector (
		.clock(clock),
		.rst(rst),
		.stReq(stReqVec),
		.stAck(stAckVec),
		.frameIn(stFrame),
		.crcIn(stCrc),
		.dstIn(stDst),
		.outReq(outReq),
		.outAck(outAck),
		.outSrc(outSrc),
		.outDst(outDst),
		.outData(outData),
		.outCrcOk(outCrcOk)
	);

endmodule

`default_nettype wire

/* testbench/busFabric_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bus_macros.svh"

module busFabric_tb;

	logic clock;
	logic rst;
	logic cmdReq;
	busPkg::nodeMask_t cmdMask;
	logic cmdAck;
	busPkg::frameData_t frameData [`BUS_NODE_COUNT];
	busPkg::crc_t frameCrc [`BUS_NODE_COUNT];
	busPkg::nodeAddr_t receiverAddr [`BUS_NODE_COUNT];
	logic outReq;
	logic outAck;
	busPkg::nodeAddr_t outSrc;
	busPkg::nodeAddr_t outDst;
	busPkg::frameData_t outData;
	logic outCrcOk;

	// Reference model state
	int rrPtr;
	int expOrder [$];
	busPkg::frameData_t expData [`BUS_NODE_COUNT];
	busPkg::crc_t expCrc [`BUS_NODE_COUNT];
	busPkg::nodeAddr_t expDst [`BUS_NODE_COUNT];
	int framesSeen;

	busPkg::nodeMask_t maskList [$];
	int cycleLimit = 0;
	int cycleCount;

	busFabric UUT (
		.clock(clock),
		.rst(rst),
		.cmdReq(cmdReq),
		.cmdMask(cmdMask),
		.cmdAck(cmdAck),
		.frameData(frameData),
		.frameCrc(frameCrc),
		.receiverAddr(receiverAddr),
		.outReq(outReq),
		.outAck(outAck),
		.outSrc(outSrc),
		.outDst(outDst),
		.outData(outData),
		.outCrcOk(outCrcOk)
	);

	always #20 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic stopOnFailure();
		$display("Test failures found");
		$fatal(1, "Simulation stopped on the first failure");
	endtask

	task automatic checkAddr(input string name, input busPkg::nodeAddr_t expected,
			input busPkg::nodeAddr_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkData(input string name, input busPkg::frameData_t expected,
			input busPkg::frameData_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
			stopOnFailure();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus and model
	//////////////////////////////////////////////////////////////////////

	task automatic randomizeInputs();
		busPkg::frameData_t data;
		for (int i = 0; i < `BUS_NODE_COUNT; i++) begin
			data = {$urandom, $urandom};
			frameData[i] <= data;
			// Roughly half the frames carry a good CRC
			if ($urandom % 2 == 0) begin
				frameCrc[i] <= busPkg::crc4(data);
			end else begin
				frameCrc[i] <= busPkg::crc_t'($urandom);
			end
			receiverAddr[i] <= busPkg::nodeAddr_t'($urandom);
		end
	endtask

	// Round-robin order from the model pointer wrapping past the last node
	function automatic void buildExpected(input busPkg::nodeMask_t mask);
		int node;
		expOrder.delete();
		for (int k = 0; k < `BUS_NODE_COUNT; k++) begin
			node = (rrPtr + k) % `BUS_NODE_COUNT;
			if (mask[node]) begin
				expOrder.push_back(node);
			end
		end
		if (expOrder.size() > 0) begin
			rrPtr = (expOrder[$] + 1) % `BUS_NODE_COUNT;
		end
	endfunction

	function automatic string commandName(input int idx, input busPkg::nodeMask_t mask);
		string kind;
		if (mask == '0) begin
			kind = "empty";
		end else if (mask == '1) begin
			kind = "full";
		end else if ($countones(mask) == 1) begin
			kind = "single";
		end else begin
			kind = "random";
		end
		return $sformatf("cmd%0d %s", idx, kind);
	endfunction

	task automatic hostHandshake(input string name);
		do begin
			@(negedge clock);
			if (outReq && expOrder.size() == 0) begin
				$display("%s: outReq went high during a command with an empty mask", name);
				stopOnFailure();
			end
		end while (!cmdAck);
		// Every frame must be out before the command completes
		if (framesSeen != expOrder.size()) begin
			$display("%s: cmdAck rose after %0d of %0d frames", name, framesSeen,
				expOrder.size());
			stopOnFailure();
		end
		@(posedge clock);
		cmdReq <= 1'b0;
		do begin
			@(negedge clock);
			if (outReq && expOrder.size() == 0) begin
				$display("%s: outReq went high during a command with an empty mask", name);
				stopOnFailure();
			end
		end while (cmdAck);
	endtask

	task automatic consumeFrames(input string name);
		int node;
		int waitCycles;
		for (int f = 0; f < expOrder.size(); f++) begin
			node = expOrder[f];
			do begin
				@(negedge clock);
			end while (!outReq);
			framesSeen++;
			checkAddr({name, " source"}, busPkg::nodeAddr_t'(node), outSrc);
			checkAddr({name, " destination"}, expDst[node], outDst);
			checkData({name, " data"}, expData[node], outData);
			checkFlag({name, " crc ok"}, busPkg::crc4(expData[node]) == expCrc[node],
				outCrcOk);
			waitCycles = int'($urandom % 4);
			@(posedge clock);
			// Host inputs move under the running command
			if (f == 0) begin
				randomizeInputs();
			end
			repeat (waitCycles) @(posedge clock);
			outAck <= 1'b1;
			do begin
				@(negedge clock);
			end while (outReq);
			waitCycles = int'($urandom % 4);
			repeat (waitCycles + 1) @(posedge clock);
			outAck <= 1'b0;
		end
	endtask

	task automatic runCommand(input busPkg::nodeMask_t mask, input string name);
		buildExpected(mask);
		framesSeen = 0;
		@(posedge clock);
		// Snapshot of what the stations will capture
		for (int i = 0; i < `BUS_NODE_COUNT; i++) begin
			expData[i] = frameData[i];
			expCrc[i] = frameCrc[i];
			expDst[i] = receiverAddr[i];
		end
		cmdMask <= mask;
		cmdReq <= 1'b1;
		fork
			hostHandshake(name);
			consumeFrames(name);
		join
		repeat (2) begin
			@(negedge clock);
			if (outReq) begin
				$display("%s: an extra frame appeared after the command", name);
				stopOnFailure();
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and timeout
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h86c));
		clock = 1'b0;
		rst = 1'b1;
		cmdReq = 1'b0;
		cmdMask = '0;
		outAck = 1'b0;
		rrPtr = 0;
		for (int i = 0; i < `BUS_NODE_COUNT; i++) begin
			frameData[i] = '0;
			frameCrc[i] = '0;
			receiverAddr[i] = '0;
		end
		maskList.push_back(busPkg::nodeMask_t'(1) << 0);
		maskList.push_back(busPkg::nodeMask_t'(1) << 10);
		maskList.push_back('1);
		maskList.push_back(busPkg::nodeMask_t'(1) << 15);
		maskList.push_back(busPkg::nodeMask_t'(1) << 5);
		maskList.push_back('0);
		maskList.push_back('1);
		repeat (40) maskList.push_back(busPkg::nodeMask_t'($urandom));
		maskList.push_back('0);
		cycleLimit = 10;
		foreach (maskList[c]) begin
			cycleLimit += $countones(maskList[c]) * 60 + 20;
		end
		repeat (5) @(posedge clock);
		rst <= 1'b0;
		foreach (maskList[c]) begin
			@(posedge clock);
			randomizeInputs();
			runCommand(maskList[c], commandName(c, maskList[c]));
		end
		$display("All tests passed!");
		$finish;
	end

	initial begin
		cycleCount = 0;
		do begin
			@(posedge clock);
			cycleCount++;
		end while (cycleCount < cycleLimit);
		$display("Timeout: the bus did not finish within %0d cycles", cycleLimit);
		stopOnFailure();
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
rtl/busPkg.sv
rtl/txDispatcher.sv
rtl/txStation.sv
rtl/busCollector.sv
rtl/busFabric.sv
testbench/busFabric_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bus fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
	--top-module busFabric_tb -o simv \
	&& ./obj_dir/simv > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx 'All tests passed!' sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
